//--- rtl/raster_pkg.sv
package raster_pkg;

    // Scan counter widths
    localparam int HCNT_W = 11;
    localparam int VCNT_W = 10;

    // Tile coordinates
    localparam int TILE_COORD_W = 6;
    localparam int TILE_X_SHIFT = 5;    // 16 pixels x 2 clocks per pixel
    localparam int TILE_Y_SHIFT = 4;    // 16 lines per tile

    // Cell storage
    localparam int CELL_W  = 8;
    localparam int COLOR_W = 3;         // Top bits of a cell

    // Output word
    localparam int PIXELS_PER_TILE = 16;
    localparam int PIXEL_WORD_W    = PIXELS_PER_TILE * COLOR_W;

    // Play field
    localparam int FIELD_COLS  = 10;
    localparam int FIELD_ROWS  = 20;
    localparam int FIELD_X0    = 6;
    localparam int FIELD_Y0    = 6;
    localparam int FIELD_CELLS = FIELD_COLS * FIELD_ROWS;

    // Next-piece preview
    localparam int PREVIEW_COLS  = 4;
    localparam int PREVIEW_ROWS  = 4;
    localparam int PREVIEW_X0    = 21;
    localparam int PREVIEW_Y0    = 8;
    localparam int PREVIEW_CELLS = PREVIEW_COLS * PREVIEW_ROWS;

    // Walls and floor around the field
    localparam int WALL_LEFT_X  = 5;
    localparam int WALL_RIGHT_X = 26;
    localparam int FLOOR_Y      = 26;

    // Frame around the preview, outer ring only
    localparam int PFRAME_X0 = 19;
    localparam int PFRAME_X1 = 25;
    localparam int PFRAME_Y0 = 6;
    localparam int PFRAME_Y1 = 12;

    localparam logic [COLOR_W-1:0] BORDER_COLOR = 3'd7;   // White

    localparam int FIELD_INDEX_W = 8;

    // What the current tile shows
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_FIELD,
        REGION_PREVIEW,
        REGION_BORDER
    } region_t;

endpackage

//--- rtl/tile_locator.sv
`timescale 1ns/100ps

module tile_locator #(
    parameter int unsigned X_OFFSET = 221,
    parameter int unsigned Y_OFFSET = 12
) (
    input  logic [raster_pkg::HCNT_W-1:0]        hcnt,
    input  logic [raster_pkg::VCNT_W-1:0]        vcnt,
    output raster_pkg::region_t                  region,
    output logic [raster_pkg::FIELD_INDEX_W-1:0] cell_index
);
    import raster_pkg::*;

    localparam logic [HCNT_W-1:0] X_OFF = HCNT_W'(X_OFFSET);
    localparam logic [VCNT_W-1:0] Y_OFF = VCNT_W'(Y_OFFSET);

    localparam int FIELD_X1   = FIELD_X0 + FIELD_COLS - 1;
    localparam int FIELD_Y1   = FIELD_Y0 + FIELD_ROWS - 1;
    localparam int PREVIEW_X1 = PREVIEW_X0 + PREVIEW_COLS - 1;
    localparam int PREVIEW_Y1 = PREVIEW_Y0 + PREVIEW_ROWS - 1;

    logic [HCNT_W-1:0]       offset_x;
    logic [VCNT_W-1:0]       offset_y;
    logic [TILE_COORD_W-1:0] tile_x;
    logic [TILE_COORD_W-1:0] tile_y;
    int                      col;
    int                      row;
    logic                    in_field;
    logic                    in_preview;
    logic                    on_wall;
    logic                    on_floor;
    logic                    on_frame;

    function automatic logic in_range(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // Wraps at the counter width when the count is still in the porch
    assign offset_x = hcnt - X_OFF;
    assign offset_y = vcnt - Y_OFF;

    assign tile_x = TILE_COORD_W'(offset_x >> TILE_X_SHIFT);
    assign tile_y = TILE_COORD_W'(offset_y >> TILE_Y_SHIFT);

    assign col = int'(tile_x);
    assign row = int'(tile_y);

    assign in_field   = in_range(col, FIELD_X0, FIELD_X1) &&
                        in_range(row, FIELD_Y0, FIELD_Y1);
    assign in_preview = in_range(col, PREVIEW_X0, PREVIEW_X1) &&
                        in_range(row, PREVIEW_Y0, PREVIEW_Y1);

    // Side walls span the field rows, floor spans the field columns
    assign on_wall  = (col == WALL_LEFT_X || col == WALL_RIGHT_X) &&
                      in_range(row, FIELD_Y0, FIELD_Y1);
    assign on_floor = (row == FLOOR_Y) && in_range(col, FIELD_X0, FIELD_X1);

    // Preview frame ring
    assign on_frame = ((row == PFRAME_Y0 || row == PFRAME_Y1) &&
                       in_range(col, PFRAME_X0, PFRAME_X1)) ||
                      ((col == PFRAME_X0 || col == PFRAME_X1) &&
                       in_range(row, PFRAME_Y0, PFRAME_Y1));

    always_comb begin
        region     = REGION_NONE;
        cell_index = '0;
        if (in_field) begin
            region     = REGION_FIELD;
            cell_index = FIELD_INDEX_W'((row - FIELD_Y0) * FIELD_COLS + (col - FIELD_X0));
        end else if (in_preview) begin
            region     = REGION_PREVIEW;
            cell_index = FIELD_INDEX_W'((row - PREVIEW_Y0) * PREVIEW_COLS +
                                        (col - PREVIEW_X0));
        end else if (on_wall || on_floor || on_frame) begin
            region = REGION_BORDER;
        end
    end

endmodule

//--- rtl/tile_painter.sv
`timescale 1ns/100ps

module tile_painter (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  raster_pkg::region_t                                   region,
    input  logic [raster_pkg::FIELD_INDEX_W-1:0]                  cell_index,
    input  logic [raster_pkg::FIELD_CELLS*raster_pkg::CELL_W-1:0] tiles,
    input  logic [raster_pkg::PREVIEW_CELLS*raster_pkg::CELL_W-1:0] next_tile,
    output logic [raster_pkg::PIXEL_WORD_W-1:0]                   pixels
);
    import raster_pkg::*;

    localparam int PREVIEW_SEL_W = $clog2(PREVIEW_CELLS);
    localparam int FIELD_TOP     = FIELD_CELLS * CELL_W - 1;
    localparam int PREVIEW_TOP   = PREVIEW_CELLS * CELL_W - 1;

    logic [PREVIEW_SEL_W-1:0] preview_sel;
    logic [CELL_W-1:0]        field_cell;
    logic [CELL_W-1:0]        preview_cell;
    logic [COLOR_W-1:0]       color;
    logic [PIXEL_WORD_W-1:0]  pixels_next;

    assign preview_sel = cell_index[PREVIEW_SEL_W-1:0];

    // Cell 0 sits in the top byte of each board vector
    assign field_cell   = tiles[FIELD_TOP - int'(cell_index) * CELL_W -: CELL_W];
    assign preview_cell = next_tile[PREVIEW_TOP - int'(preview_sel) * CELL_W -: CELL_W];

    always_comb begin
        case (region)
            REGION_FIELD:   color = field_cell[CELL_W-1 -: COLOR_W];
            REGION_PREVIEW: color = preview_cell[CELL_W-1 -: COLOR_W];
            default:        color = BORDER_COLOR;
        endcase

        // Leftmost pixel stays black as a tile separator
        if (region == REGION_NONE) begin
            pixels_next = '0;
        end else begin
            pixels_next = {COLOR_W'(0), {(PIXELS_PER_TILE - 1){color}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixels <= '0;
        end else begin
            pixels <= pixels_next;
        end
    end

endmodule

//--- rtl/raster.sv
`timescale 1ns/100ps

module raster #(
    parameter int unsigned X_OFFSET = 221,   // Porch clocks, less one tile of lead
    parameter int unsigned Y_OFFSET = 12     // Lines above the visible area
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [raster_pkg::HCNT_W-1:0]                           hcnt,
    input  logic [raster_pkg::VCNT_W-1:0]                           vcnt,
    input  logic [raster_pkg::FIELD_CELLS*raster_pkg::CELL_W-1:0]   tiles,
    input  logic [raster_pkg::PREVIEW_CELLS*raster_pkg::CELL_W-1:0] next_tile,
    output logic [raster_pkg::PIXEL_WORD_W-1:0]                     pixels
);
    import raster_pkg::*;

    region_t                  region;
    logic [FIELD_INDEX_W-1:0] cell_index;

    // Combinational tile lookup
    tile_locator #(
        .X_OFFSET (X_OFFSET),
        .Y_OFFSET (Y_OFFSET)
    ) i_tile_locator (
        .hcnt       (hcnt),
        .vcnt       (vcnt),
        .region     (region),
        .cell_index (cell_index)
    );

    // One register stage to the pixel word
    tile_painter i_tile_painter (
        .clk        (clk),
        .rst        (rst),
        .region     (region),
        .cell_index (cell_index),
        .tiles      (tiles),
        .next_tile  (next_tile),
        .pixels     (pixels)
    );

endmodule

//--- verif/raster_checker.sv
`timescale 1ns/100ps

module raster_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [raster_pkg::HCNT_W-1:0]       hcnt,
    input  logic [raster_pkg::VCNT_W-1:0]       vcnt,
    input  logic [raster_pkg::PIXEL_WORD_W-1:0] pixels,
    input  logic [raster_pkg::PIXEL_WORD_W-1:0] exp_pixels,
    input  logic                                exp_valid,
    input  logic                                report,
    output int                                  vectors_checked,
    output int                                  error_count
);
    import raster_pkg::*;

    logic [HCNT_W-1:0]       hcnt_q;
    logic [VCNT_W-1:0]       vcnt_q;
    logic [PIXEL_WORD_W-1:0] exp_q;
    logic                    exp_valid_q = 1'b0;
    logic                    rst_q = 1'b0;
    logic                    hold_zero_q = 1'b0;
    int                      checked_n = 0;
    int                      reset_n = 0;
    int                      errors_n = 0;

    assign vectors_checked = checked_n;
    assign error_count     = errors_n;

    task automatic show_mismatch(input logic [PIXEL_WORD_W-1:0] expected);
        errors_n++;
        $display("MISMATCH time=%0t signal=pixels expected=%h actual=%h hcnt=%h vcnt=%h",
                 $time, expected, pixels, hcnt_q, vcnt_q);
    endtask

    // Capture what the DUT samples at the same edge
    always @(posedge clk) begin
        hcnt_q      <= hcnt;
        vcnt_q      <= vcnt;
        exp_q       <= exp_pixels;
        exp_valid_q <= exp_valid && !rst;
        hold_zero_q <= rst || rst_q;    // In reset or first edge after it
        rst_q       <= rst;
    end

    // Pixel register is stable at the falling edge
    always @(negedge clk) begin
        if (exp_valid_q) begin
            checked_n++;
            if (pixels !== exp_q) begin
                show_mismatch(exp_q);
            end
        end else if (hold_zero_q) begin
            reset_n++;
            if (pixels !== '0) begin
                show_mismatch('0);
            end
        end
    end

    always @(posedge report) begin
        $display("Summary: %0d pixel words checked, %0d reset cycles checked, %0d errors",
                 checked_n, reset_n, errors_n);
    end

endmodule

//--- verif/raster_tb.sv
`timescale 1ns/100ps

module raster_tb;
    import raster_pkg::*;

    localparam int    NUM_VECTORS  = 60;
    localparam int    STIM_WORDS   = 3 * NUM_VECTORS;   // hcnt, vcnt, expected
    localparam int    RESET_CYCLES = 16;
    localparam int    CLK_PERIOD   = 8;
    localparam int    TIMEOUT_NS   = (NUM_VECTORS + RESET_CYCLES + 10) * CLK_PERIOD;
    localparam string STIM_FILE    = "verif/raster_stim.txt";

    logic                              clk;
    logic                              rst;
    logic [HCNT_W-1:0]                 hcnt;
    logic [VCNT_W-1:0]                 vcnt;
    logic [FIELD_CELLS*CELL_W-1:0]     tiles;
    logic [PREVIEW_CELLS*CELL_W-1:0]   next_tile;
    logic [PIXEL_WORD_W-1:0]           pixels;

    logic [PIXEL_WORD_W-1:0]           exp_pixels;
    logic                              exp_valid;
    logic                              report_req;
    logic                              timed_out;
    int                                vectors_checked;
    int                                error_count;
    int                                stim_failures;
    integer                            seed;
    logic [PIXEL_WORD_W-1:0]           stim_mem [0:STIM_WORDS-1];

    raster i_raster (
        .clk       (clk),
        .rst       (rst),
        .hcnt      (hcnt),
        .vcnt      (vcnt),
        .tiles     (tiles),
        .next_tile (next_tile),
        .pixels    (pixels)
    );

    raster_checker i_checker (
        .clk             (clk),
        .rst             (rst),
        .hcnt            (hcnt),
        .vcnt            (vcnt),
        .pixels          (pixels),
        .exp_pixels      (exp_pixels),
        .exp_valid       (exp_valid),
        .report          (report_req || timed_out),
        .vectors_checked (vectors_checked),
        .error_count     (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Color in the top bits follows the cell number, low bits are noise
    task automatic fill_board();
        logic [31:0]               rnd;
        logic [COLOR_W-1:0]        color;
        logic [CELL_W-COLOR_W-1:0] low_bits;
        for (int i = 0; i < FIELD_CELLS; i++) begin
            rnd      = $random(seed);
            color    = COLOR_W'(i % 8);
            low_bits = rnd[CELL_W-COLOR_W-1:0];
            tiles[FIELD_CELLS*CELL_W-1 - i*CELL_W -: CELL_W] = {color, low_bits};
        end
        for (int i = 0; i < PREVIEW_CELLS; i++) begin
            rnd      = $random(seed);
            color    = COLOR_W'((i + 3) % 8);
            low_bits = rnd[CELL_W-COLOR_W-1:0];
            next_tile[PREVIEW_CELLS*CELL_W-1 - i*CELL_W -: CELL_W] = {color, low_bits};
        end
    endtask

    task automatic load_stim();
        integer fd;
        int     missing;
        missing = 0;
        for (int a = 0; a < STIM_WORDS; a++) begin
            stim_mem[a] = {16'hFFFF, 32'(a)};   // No valid entry has these top bits
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            stim_failures++;
        end else begin
            $fclose(fd);
            $readmemh(STIM_FILE, stim_mem);
            for (int a = 0; a < STIM_WORDS; a++) begin
                if (stim_mem[a][PIXEL_WORD_W-1 -: 16] == 16'hFFFF) begin
                    missing++;
                end
            end
            if (missing != 0) begin
                $display("Stimulus file %s is short, %0d of %0d entries were not loaded",
                         STIM_FILE, missing, STIM_WORDS);
                stim_failures++;
            end
        end
    endtask

    task automatic apply_vector(input int k);
        hcnt       = stim_mem[3*k][HCNT_W-1:0];
        vcnt       = stim_mem[3*k+1][VCNT_W-1:0];
        exp_pixels = stim_mem[3*k+2];
        exp_valid  = 1'b1;
    endtask

    task automatic finish_run();
        report_req = 1'b1;
        #1;
        if (stim_failures == 0 && error_count == 0 && vectors_checked == NUM_VECTORS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        seed          = 6;
        stim_failures = 0;
        rst           = 1'b1;
        hcnt          = 11'h17D;    // Left wall tile, so reset has to clear a white word
        vcnt          = 10'h06C;
        tiles         = '0;
        next_tile     = '0;
        exp_pixels    = '0;
        exp_valid     = 1'b0;
        report_req    = 1'b0;
        fill_board();
        load_stim();
        repeat (RESET_CYCLES) @(negedge clk);
        rst  = 1'b0;
        hcnt = '0;      // Background tile for the first edge after reset
        vcnt = '0;
        if (stim_failures == 0) begin
            for (int k = 0; k < NUM_VECTORS; k++) begin
                @(negedge clk);
                apply_vector(k);
            end
            @(negedge clk);
            exp_valid = 1'b0;
            wait (vectors_checked == NUM_VECTORS);
        end
        finish_run();
    end

    initial begin
        timed_out = 1'b0;
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, not all pixel words were checked", TIMEOUT_NS);
        timed_out = 1'b1;
        #1;
        $display("Something failed");
        $finish;
    end

endmodule

//--- verif/raster_stim.txt
// Columns: hcnt vcnt expected_pixels, all hex, one vector per clock
// Pixel 0 is the top three bits of the expected word
0DD 00C 000000000000
0FC 0CC 000000000000
0DC 06C 000000000000
19D 005 000000000000
19D 06B 000000000000
19D 06C 000000000000
2BD 06C 049249249249
19D 19C 1B6DB6DB6DB6
2BD 19C 1FFFFFFFFFFF
1BD 07C 0DB6DB6DB6DB
1DD 08C 1B6DB6DB6DB6
1FD 09C 049249249249
21D 0AC 124924924924
23D 0BC 1FFFFFFFFFFF
25D 0CC 092492492492
27D 0DC 16DB6DB6DB6D
29D 0FC 092492492492
1DD 14C 1B6DB6DB6DB6
21D 19C 092492492492
1BD 07B 049249249249
1BC 07C 092492492492
2DC 1AB 1FFFFFFFFFFF
2DD 1AB 000000000000
29D 08C 124924924924
23D 14C 049249249249
37D 08C 0DB6DB6DB6DB
39D 08C 124924924924
3BD 09C 049249249249
3DD 0AC 1B6DB6DB6DB6
37D 0BC 1FFFFFFFFFFF
3DD 0BC 092492492492
39D 0AC 124924924924
3FC 0CB 092492492492
3BD 08C 16DB6DB6DB6D
39C 09C 1FFFFFFFFFFF
17D 06C 1FFFFFFFFFFF
19C 19C 1FFFFFFFFFFF
41D 06C 1FFFFFFFFFFF
41D 19C 1FFFFFFFFFFF
41D 14C 1FFFFFFFFFFF
19D 1AC 1FFFFFFFFFFF
2BD 1AC 1FFFFFFFFFFF
17D 1AC 000000000000
41D 1AC 000000000000
2BD 1BC 000000000000
43D 0AC 000000000000
33D 06C 1FFFFFFFFFFF
3FD 06C 1FFFFFFFFFFF
35D 06C 1FFFFFFFFFFF
33D 0AC 1FFFFFFFFFFF
3FD 0AC 1FFFFFFFFFFF
39D 0CC 1FFFFFFFFFFF
3FD 0CC 1FFFFFFFFFFF
35D 0AC 000000000000
39D 07C 000000000000
33D 0DC 000000000000
2DD 06C 000000000000
1DD 08C 1B6DB6DB6DB6
0DD 00C 000000000000
2BD 06C 049249249249

//--- filelist.f
rtl/raster_pkg.sv
rtl/tile_locator.sv
rtl/tile_painter.sv
rtl/raster.sv
verif/raster_checker.sv
verif/raster_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the raster testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps --top-module raster_tb \
    -f filelist.f -o raster_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/raster_sim > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
